// File: filelist.f
+incdir+common
common/fx2_bus_pkg.sv
common/fx2_packet_pkg.sv
logic/fx2_endpoint_scheduler.sv
fx2_reader/fx2_packet_reader.sv
fx2_writer/fx2_command_writer.sv
logic/fx2_interface.sv
verification/fx2_interface_assertions.sv
verification/fx2_interface_tb.sv

// File: Makefile
TOOL     := verilator
FLAGS    := --binary --assert --timing
TOP      := fx2_interface_tb
FILELIST := filelist.f
OBJ_DIR  := obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "  help   list these targets"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// File: verification/fx2_interface_tb.sv
// ======================================================================
// FX2 interface testbench
// Host FIFO, decoder and encoder models around the slave-FIFO glue
// ======================================================================
`timescale 1ns/1ps
`default_nettype none

`include "fx2_cfg.svh"

module fx2_interface_tb;

    logic usb_ifclk;
    logic reset;
    logic [7:0] usb_data_out;
    logic usb_ep2_empty;
    logic usb_ep4_empty;
    logic usb_ep8_full;
    logic cmd_in_ready;
    logic [7:0] cmd_out_id;
    logic [15:0] cmd_out_length;
    logic [7:0] cmd_out_data;
    logic cmd_out_valid;
    wire usb_slwr;
    wire usb_slrd;
    wire usb_sloe;
    fx2_bus_pkg::ep_addr_t usb_addr;
    wire [7:0] usb_data_in;
    wire [7:0] ep2_port_data;
    wire [3:0] ep2_port_write;
    wire [7:0] cmd_in_id;
    wire [15:0] cmd_in_length;
    wire [7:0] cmd_in_data;
    wire cmd_in_valid;
    wire cmd_out_ready;

    // Host side FIFO contents, bytes held back, and expected traffic
    logic [7:0] q2[$];
    logic [7:0] q4[$];
    logic [7:0] held2[$];
    int exp2_port[$];
    logic [7:0] exp2_data[$];
    logic [7:0] exp4_data[$];
    logic [7:0] enc_data[$];
    logic [7:0] ep8_rec[$];
    int exp4_id;
    int exp4_len;
    int error_count;

    fx2_interface fx2_interface_inst (.*);

    bind fx2_interface fx2_interface_assertions fx2_interface_assertions_inst (
        .usb_ifclk(usb_ifclk), .reset(reset), .usb_slrd(usb_slrd), .usb_slwr(usb_slwr),
        .usb_addr(usb_addr), .usb_ep2_empty(usb_ep2_empty),
        .usb_ep4_empty(usb_ep4_empty), .usb_ep8_full(usb_ep8_full),
        .ep2_port_write(ep2_port_write)
    );

    always #10 usb_ifclk = ~usb_ifclk;

    task automatic stop_run();
        error_count++;
        $display("Done: errors found");
        $fatal(1);
    endtask

    task automatic check_value(string name, int expected, int actual);
        assert (expected == actual) else begin
            $display("error %s: expected %0h, actual %0h", name, expected, actual);
            stop_run();
        end
    endtask

    // Inputs change 1 ns after the edge, with random gaps and stalls
    task automatic drive_inputs();
        usb_ep2_empty = (q2.size() == 0) || ($urandom % 4 == 0);
        usb_ep4_empty = (q4.size() == 0) || ($urandom % 4 == 0);
        if (usb_addr == fx2_bus_pkg::EP4) begin
            usb_data_out = (q4.size() > 0) ? q4[0] : 8'h00;
        end else begin
            usb_data_out = (q2.size() > 0) ? q2[0] : 8'h00;
        end
        cmd_in_ready = ($urandom % 3 != 0);
        // Full never lasts two cycles, well under the EP8 timeout
        usb_ep8_full = !usb_ep8_full && ($urandom % 5 == 0);
        cmd_out_valid = (enc_data.size() > 0);
        cmd_out_data = (enc_data.size() > 0) ? enc_data[0] : 8'h00;
        // The encoder withdraws its command once the EP8 header is out
        if (ep8_rec.size() > 0) begin
            cmd_out_id = 8'h00;
        end
    endtask

    // One clock: check and record what the DUT did, then update models
    // Outputs are sampled at the falling edge, inputs change after the rising one
    task automatic step();
        @(negedge usb_ifclk);
        check_value("usb_sloe", 0, int'(usb_sloe));
        if (ep2_port_write != '0) begin
            if (exp2_data.size() == 0) begin
                $display("EP2 port write seen with no payload byte expected");
                stop_run();
            end
            check_value("ep2_port_write", 1 << exp2_port[0], int'(ep2_port_write));
            check_value("ep2_port_data", int'(exp2_data[0]), int'(ep2_port_data));
            void'(exp2_port.pop_front());
            void'(exp2_data.pop_front());
        end
        if (cmd_in_valid && cmd_in_ready) begin
            if (exp4_data.size() == 0) begin
                $display("Decoder received a byte with none expected");
                stop_run();
            end
            check_value("cmd_in_id", exp4_id, int'(cmd_in_id));
            check_value("cmd_in_length", exp4_len, int'(cmd_in_length));
            check_value("cmd_in_data", int'(exp4_data[0]), int'(cmd_in_data));
            void'(exp4_data.pop_front());
        end
        if (!usb_slwr) ep8_rec.push_back(usb_data_in);
        if (!usb_slrd && usb_addr == fx2_bus_pkg::EP2) void'(q2.pop_front());
        if (!usb_slrd && usb_addr == fx2_bus_pkg::EP4) void'(q4.pop_front());
        if (cmd_out_valid && cmd_out_ready) void'(enc_data.pop_front());
        @(posedge usb_ifclk);
        #1;
        drive_inputs();
    endtask

    // Kind 0 waits for EP2 to drain, 1 for EP4, 2 for target EP8 bytes
    task automatic wait_for(int kind, int target, string what);
        int n;
        n = 0;
        while (!((kind == 0 && exp2_data.size() == 0 && q2.size() == 0) ||
                 (kind == 1 && exp4_data.size() == 0 && q4.size() == 0) ||
                 (kind == 2 && ep8_rec.size() >= target))) begin
            if (n >= 3000) begin
                $display("Timed out waiting for %s", what);
                stop_run();
            end
            step();
            n++;
        end
    endtask

    // Bytes beyond cut stay in held2 until the test releases them
    task automatic send_ep2(int port, int len, int cut);
        fx2_packet_pkg::header_word_u hw;
        logic [7:0] b;
        hw.port_sel.reserved = '0;
        hw.port_sel.port = 2'(port);
        q2.push_back(`FX2_HEADER_BYTE);
        q2.push_back(hw);
        q2.push_back(8'(len >> 8));
        q2.push_back(8'(len));
        for (int i = 0; i < len; i++) begin
            b = 8'($urandom);
            exp2_port.push_back(port);
            exp2_data.push_back(b);
            if (i < cut) q2.push_back(b);
            else held2.push_back(b);
        end
    endtask

    task automatic send_ep4(int id, int len);
        fx2_packet_pkg::header_word_u hw;
        logic [7:0] b;
        hw.command_id = 8'(id);
        exp4_id = id;
        exp4_len = len;
        q4.push_back(`FX2_HEADER_BYTE);
        q4.push_back(hw);
        q4.push_back(8'(len >> 8));
        q4.push_back(8'(len));
        for (int i = 0; i < len; i++) begin
            b = 8'($urandom);
            exp4_data.push_back(b);
            q4.push_back(b);
        end
    endtask

    // Encoder offers given bytes for a packet of len bytes, so at most
    // the first len of them belong in the EP8 packet
    task automatic run_ep8(string name, int id, int len, int given);
        logic [7:0] sent[$];
        int expected;
        expected = (given < len) ? given : len;
        ep8_rec.delete();
        for (int i = 0; i < given; i++) begin
            sent.push_back(8'($urandom));
        end
        enc_data = sent;
        cmd_out_id = 8'(id);
        cmd_out_length = 16'(len);
        wait_for(2, 4 + expected, name);
        check_value({name, " header"}, int'(`FX2_HEADER_BYTE), int'(ep8_rec[0]));
        check_value({name, " id"}, id, int'(ep8_rec[1]));
        check_value({name, " length high"}, len >> 8, int'(ep8_rec[2]));
        check_value({name, " length low"}, len & 'hFF, int'(ep8_rec[3]));
        for (int i = 0; i < expected; i++) begin
            check_value({name, " data"}, int'(sent[i]), int'(ep8_rec[4 + i]));
        end
    endtask

    initial begin
        void'($urandom(32'h68d822a5));
        error_count = 0;
        usb_ifclk = 1'b0;
        reset = 1'b1;
        usb_data_out = 8'h00;
        usb_ep2_empty = 1'b1;
        usb_ep4_empty = 1'b1;
        usb_ep8_full = 1'b0;
        cmd_in_ready = 1'b0;
        cmd_out_id = 8'h00;
        cmd_out_length = 16'h0000;
        cmd_out_data = 8'h00;
        cmd_out_valid = 1'b0;
        repeat (8) @(posedge usb_ifclk);
        #1 reset = 1'b0;

        // Routing to every port, then junk ahead of a header
        for (int p = 0; p < `FX2_NUM_PORTS; p++) begin
            send_ep2(p, 3 + p * 4, 1000);
            wait_for(0, 0, "EP2 routing");
        end
        for (int i = 0; i < 5; i++) q2.push_back(8'($urandom % 255));
        send_ep2(2, 7, 1000);
        wait_for(0, 0, "EP2 resync");

        send_ep4(8'h5A, 12);
        wait_for(1, 0, "EP4 handoff");

        // EP2 stalls halfway while an EP4 packet is served
        send_ep2(1, 10, 4);
        send_ep4(8'h33, 6);
        wait_for(1, 0, "EP4 between EP2 halves");
        while (held2.size() > 0) q2.push_back(held2.pop_front());
        wait_for(0, 0, "EP2 resume");

        // The encoder stays valid past the packet end, surplus bytes stay unsent
        run_ep8("ep8 packet", 8'h21, 9, 11);
        run_ep8("ep8 timeout", 8'h42, 8, 3);
        send_ep2(3, 5, 1000);
        wait_for(0, 0, "EP2 after EP8 timeout");
        check_value("ep8 timeout length", 7, ep8_rec.size());

        if (error_count == 0) begin
            $display("Done: no errors");
            $finish;
        end else begin
            stop_run();
        end
    end

endmodule

`default_nettype wire

// File: verification/fx2_interface_assertions.sv
// ======================================================================
// FX2 interface port checks
// Strobe exclusivity, read legality, port write one-hot, EP8 full rule
// ======================================================================
`timescale 1ns/1ps
`default_nettype none

`include "fx2_cfg.svh"

module fx2_interface_assertions (
    input wire usb_ifclk,
    input wire reset,
    input wire usb_slrd,
    input wire usb_slwr,
    input fx2_bus_pkg::ep_addr_t usb_addr,
    input wire usb_ep2_empty,
    input wire usb_ep4_empty,
    input wire usb_ep8_full,
    input wire [`FX2_NUM_PORTS-1:0] ep2_port_write
);

    // The bus is shared, so a read and a write can never overlap
    assert property (@(posedge usb_ifclk) disable iff (reset)
        !(!usb_slrd && !usb_slwr))
    else $error("SLRD and SLWR are low in the same cycle");

    // Reads only go to EP2 or EP4, and only when that FIFO has data
    assert property (@(posedge usb_ifclk) disable iff (reset)
        !usb_slrd |-> ((usb_addr == fx2_bus_pkg::EP2) && !usb_ep2_empty) ||
                      ((usb_addr == fx2_bus_pkg::EP4) && !usb_ep4_empty))
    else $error("SLRD is low on an empty or unserved endpoint");

    // Each EP2 byte goes to one tracking FIFO at most
    assert property (@(posedge usb_ifclk) disable iff (reset)
        $onehot0(ep2_port_write))
    else $error("More than one tracking-FIFO write strobe is set");

    // A write burst only starts after a cycle where EP8 had room
    assert property (@(posedge usb_ifclk) disable iff (reset)
        $fell(usb_slwr) |-> !$past(usb_ep8_full))
    else $error("EP8 write started while the FIFO was full");

endmodule

`default_nettype wire

// File: logic/fx2_interface.sv
// ======================================================================
// FX2 slave-FIFO interface
// Connects the scheduler, packet reader and command writer
// ======================================================================
`timescale 1ns/1ps
`default_nettype none

`include "fx2_cfg.svh"

module fx2_interface (
    input wire usb_ifclk,
    input wire reset,
    // FX2 slave-FIFO bus
    output logic usb_slwr,
    output logic usb_slrd,
    output logic usb_sloe,
    output fx2_bus_pkg::ep_addr_t usb_addr,
    output logic [`FX2_DATA_W-1:0] usb_data_in,
    input wire [`FX2_DATA_W-1:0] usb_data_out,
    input wire usb_ep2_empty,
    input wire usb_ep4_empty,
    input wire usb_ep8_full,
    // Tracking-FIFO write ports
    output logic [`FX2_DATA_W-1:0] ep2_port_data,
    output logic [`FX2_NUM_PORTS-1:0] ep2_port_write,
    // Command decoder
    output logic [7:0] cmd_in_id,
    output logic [`FX2_LEN_W-1:0] cmd_in_length,
    output logic [`FX2_DATA_W-1:0] cmd_in_data,
    output logic cmd_in_valid,
    input wire cmd_in_ready,
    // Command encoder
    input wire [7:0] cmd_out_id,
    input wire [`FX2_LEN_W-1:0] cmd_out_length,
    input wire [`FX2_DATA_W-1:0] cmd_out_data,
    input wire cmd_out_valid,
    output logic cmd_out_ready
);

    logic ep2_grant;
    logic ep4_grant;
    logic ep8_grant;
    logic reader_yield;
    logic writer_yield;

    // FX2 drives the data bus at all times
    assign usb_sloe = 1'b0;

    fx2_endpoint_scheduler fx2_endpoint_scheduler_inst (
        .usb_ifclk(usb_ifclk), .reset(reset),
        .reader_yield(reader_yield), .writer_yield(writer_yield),
        .usb_addr(usb_addr),
        .ep2_grant(ep2_grant), .ep4_grant(ep4_grant), .ep8_grant(ep8_grant)
    );

    fx2_packet_reader fx2_packet_reader_inst (
        .usb_ifclk(usb_ifclk), .reset(reset),
        .ep2_grant(ep2_grant), .ep4_grant(ep4_grant),
        .usb_data_out(usb_data_out),
        .usb_ep2_empty(usb_ep2_empty), .usb_ep4_empty(usb_ep4_empty),
        .cmd_in_ready(cmd_in_ready), .usb_slrd(usb_slrd),
        .ep2_port_data(ep2_port_data), .ep2_port_write(ep2_port_write),
        .cmd_in_id(cmd_in_id), .cmd_in_length(cmd_in_length),
        .cmd_in_data(cmd_in_data), .cmd_in_valid(cmd_in_valid),
        .reader_yield(reader_yield)
    );

    fx2_command_writer fx2_command_writer_inst (
        .usb_ifclk(usb_ifclk), .reset(reset),
        .ep8_grant(ep8_grant), .usb_ep8_full(usb_ep8_full),
        .cmd_out_id(cmd_out_id), .cmd_out_length(cmd_out_length),
        .cmd_out_data(cmd_out_data), .cmd_out_valid(cmd_out_valid),
        .usb_slwr(usb_slwr), .usb_data_in(usb_data_in),
        .cmd_out_ready(cmd_out_ready), .writer_yield(writer_yield)
    );

endmodule

`default_nettype wire

// File: fx2_writer/fx2_command_writer.sv
// ======================================================================
// FX2 command writer
// Frames command encoder output into EP8 packets, with an idle
// timeout on the data phase
// ======================================================================
`timescale 1ns/1ps
`default_nettype none

`include "fx2_cfg.svh"

module fx2_command_writer (
    input wire usb_ifclk,
    input wire reset,
    input wire ep8_grant,
    input wire usb_ep8_full,
    input wire [7:0] cmd_out_id,
    input wire [`FX2_LEN_W-1:0] cmd_out_length,
    input wire [`FX2_DATA_W-1:0] cmd_out_data,
    input wire cmd_out_valid,
    output logic usb_slwr,
    output logic [`FX2_DATA_W-1:0] usb_data_in,
    output logic cmd_out_ready,
    output logic writer_yield
);

    // Wide enough to hold the full timeout count
    localparam int IDLE_W = $clog2(`FX2_EP8_WAIT_CYCLES + 1);

    fx2_packet_pkg::packet_phase_t phase;
    logic [`FX2_LEN_W-1:0] len_q;
    logic [`FX2_LEN_W-1:0] byte_cnt;
    logic [IDLE_W-1:0] idle_cnt;
    logic start;
    logic transfer;

    // A packet starts only for a real command with room in EP8
    assign start = ep8_grant && (phase == fx2_packet_pkg::PHASE_WAITING) &&
                   (cmd_out_id != '0) && !usb_ep8_full;

    // The encoder is asked for data only while EP8 can take it
    assign cmd_out_ready = ep8_grant && (phase == fx2_packet_pkg::PHASE_DATA) && !usb_ep8_full;
    assign transfer = cmd_out_ready && cmd_out_valid;

    // Nothing to send, or the packet has just finished
    assign writer_yield = ep8_grant &&
        (((phase == fx2_packet_pkg::PHASE_WAITING) && !start) ||
         (phase == fx2_packet_pkg::PHASE_DONE));

    // Every byte is registered, so SLWR and data land together one clock
    // after the decision to write them
    always_ff @(posedge usb_ifclk) begin
        if (reset) begin
            phase <= fx2_packet_pkg::PHASE_WAITING;
            usb_slwr <= fx2_bus_pkg::STROBE_IDLE;
        end else begin
            usb_slwr <= fx2_bus_pkg::STROBE_IDLE;
            case (phase)
                fx2_packet_pkg::PHASE_WAITING: begin
                    if (start) begin
                        usb_slwr <= fx2_bus_pkg::STROBE_ACTIVE;
                        usb_data_in <= `FX2_HEADER_BYTE;
                        phase <= fx2_packet_pkg::PHASE_HEADER_SELECT;
                    end
                end
                fx2_packet_pkg::PHASE_HEADER_SELECT: begin
                    usb_slwr <= fx2_bus_pkg::STROBE_ACTIVE;
                    usb_data_in <= cmd_out_id;
                    phase <= fx2_packet_pkg::PHASE_LENGTH_UPPER;
                end
                fx2_packet_pkg::PHASE_LENGTH_UPPER: begin
                    // Length is frozen here so the encoder may move on
                    usb_slwr <= fx2_bus_pkg::STROBE_ACTIVE;
                    usb_data_in <= cmd_out_length[`FX2_LEN_W-1 -: `FX2_DATA_W];
                    len_q <= cmd_out_length;
                    phase <= fx2_packet_pkg::PHASE_LENGTH_LOWER;
                end
                fx2_packet_pkg::PHASE_LENGTH_LOWER: begin
                    usb_slwr <= fx2_bus_pkg::STROBE_ACTIVE;
                    usb_data_in <= len_q[`FX2_DATA_W-1:0];
                    byte_cnt <= '0;
                    idle_cnt <= '0;
                    if (len_q == '0) begin
                        phase <= fx2_packet_pkg::PHASE_DONE;
                    end else begin
                        phase <= fx2_packet_pkg::PHASE_DATA;
                    end
                end
                fx2_packet_pkg::PHASE_DATA: begin
                    if (transfer) begin
                        usb_slwr <= fx2_bus_pkg::STROBE_ACTIVE;
                        usb_data_in <= cmd_out_data;
                        byte_cnt <= byte_cnt + 1'b1;
                        idle_cnt <= '0;
                        if (byte_cnt == len_q - 1'b1) begin
                            phase <= fx2_packet_pkg::PHASE_DONE;
                        end
                    end else begin
                        // Full cycles count as idle just like missing data
                        idle_cnt <= idle_cnt + 1'b1;
                        if (idle_cnt == IDLE_W'(`FX2_EP8_WAIT_CYCLES - 1)) begin
                            phase <= fx2_packet_pkg::PHASE_DONE;
                        end
                    end
                end
                default: begin
                    phase <= fx2_packet_pkg::PHASE_WAITING;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: fx2_reader/fx2_packet_reader.sv
// ======================================================================
// FX2 packet reader
// Parses EP2 data and EP4 command packets from the slave FIFO and
// routes payload to the tracking-FIFO ports or the command decoder
// ======================================================================
`timescale 1ns/1ps
`default_nettype none

`include "fx2_cfg.svh"

module fx2_packet_reader (
    input wire usb_ifclk,
    input wire reset,
    input wire ep2_grant,
    input wire ep4_grant,
    input wire [`FX2_DATA_W-1:0] usb_data_out,
    input wire usb_ep2_empty,
    input wire usb_ep4_empty,
    input wire cmd_in_ready,
    output logic usb_slrd,
    output logic [`FX2_DATA_W-1:0] ep2_port_data,
    output logic [`FX2_NUM_PORTS-1:0] ep2_port_write,
    output logic [7:0] cmd_in_id,
    output logic [`FX2_LEN_W-1:0] cmd_in_length,
    output logic [`FX2_DATA_W-1:0] cmd_in_data,
    output logic cmd_in_valid,
    output logic reader_yield
);

    // Entry 0 belongs to EP2 and entry 1 to EP4
    fx2_packet_pkg::packet_phase_t phase [2];
    logic [`FX2_LEN_W-1:0] length [2];
    logic [`FX2_LEN_W-1:0] count [2];

    // Fields latched from the select byte
    logic [1:0] port_sel;
    logic [7:0] cmd_id;

    fx2_packet_pkg::header_word_u select_word;
    fx2_packet_pkg::packet_phase_t cur_phase;
    logic sel;
    logic active;
    logic fifo_empty;
    logic read_byte;
    logic decoder_stall;

    // EP4 is the only other endpoint this block ever serves
    assign sel = ep4_grant;
    assign active = ep2_grant | ep4_grant;
    assign fifo_empty = sel ? usb_ep4_empty : usb_ep2_empty;
    assign cur_phase = phase[sel];
    assign select_word = usb_data_out;

    // Decoder back-pressure only matters while EP4 payload is moving
    assign decoder_stall = sel && (cur_phase == fx2_packet_pkg::PHASE_DATA) && !cmd_in_ready;

    // A byte is consumed on every cycle the strobe is low
    assign read_byte = active && !fifo_empty && !decoder_stall &&
                       (cur_phase != fx2_packet_pkg::PHASE_DONE);
    assign usb_slrd = read_byte ? fx2_bus_pkg::STROBE_ACTIVE : fx2_bus_pkg::STROBE_IDLE;

    // Give up the endpoint when its FIFO runs dry, when a packet ends,
    // or when the first byte turns out not to be a header
    assign reader_yield = active && (fifo_empty ||
        (cur_phase == fx2_packet_pkg::PHASE_DONE) ||
        ((cur_phase == fx2_packet_pkg::PHASE_WAITING) && read_byte &&
         (usb_data_out != `FX2_HEADER_BYTE)));

    // Exactly one tracking-FIFO strobe per EP2 payload byte
    always_comb begin
        ep2_port_write = '0;
        if (ep2_grant && (phase[0] == fx2_packet_pkg::PHASE_DATA) && read_byte) begin
            ep2_port_write[port_sel] = 1'b1;
        end
    end

    assign ep2_port_data = usb_data_out;

    // Decoder link sees the bus byte directly in the EP4 data phase
    assign cmd_in_id = cmd_id;
    assign cmd_in_length = length[1];
    assign cmd_in_data = usb_data_out;
    assign cmd_in_valid = ep4_grant && (phase[1] == fx2_packet_pkg::PHASE_DATA) &&
                          !usb_ep4_empty;

    // Only the served endpoint advances, the other keeps its place
    always_ff @(posedge usb_ifclk) begin
        if (reset) begin
            for (int i = 0; i < 2; i++) begin
                phase[i] <= fx2_packet_pkg::PHASE_WAITING;
            end
        end else if (active) begin
            case (cur_phase)
                fx2_packet_pkg::PHASE_WAITING: begin
                    // Anything other than a header is dropped here
                    if (read_byte && (usb_data_out == `FX2_HEADER_BYTE)) begin
                        phase[sel] <= fx2_packet_pkg::PHASE_HEADER_SELECT;
                    end
                end
                fx2_packet_pkg::PHASE_HEADER_SELECT: begin
                    if (read_byte) begin
                        if (sel) begin
                            cmd_id <= select_word.command_id;
                        end else begin
                            port_sel <= select_word.port_sel.port;
                        end
                        phase[sel] <= fx2_packet_pkg::PHASE_LENGTH_UPPER;
                    end
                end
                fx2_packet_pkg::PHASE_LENGTH_UPPER: begin
                    if (read_byte) begin
                        length[sel][`FX2_LEN_W-1 -: `FX2_DATA_W] <= usb_data_out;
                        phase[sel] <= fx2_packet_pkg::PHASE_LENGTH_LOWER;
                    end
                end
                fx2_packet_pkg::PHASE_LENGTH_LOWER: begin
                    if (read_byte) begin
                        length[sel][`FX2_DATA_W-1:0] <= usb_data_out;
                        count[sel] <= '0;
                        // An empty payload skips the data phase
                        if ((length[sel][`FX2_LEN_W-1 -: `FX2_DATA_W] == '0) &&
                            (usb_data_out == '0)) begin
                            phase[sel] <= fx2_packet_pkg::PHASE_DONE;
                        end else begin
                            phase[sel] <= fx2_packet_pkg::PHASE_DATA;
                        end
                    end
                end
                fx2_packet_pkg::PHASE_DATA: begin
                    if (read_byte) begin
                        count[sel] <= count[sel] + 1'b1;
                        if (count[sel] == length[sel] - 1'b1) begin
                            phase[sel] <= fx2_packet_pkg::PHASE_DONE;
                        end
                    end
                end
                default: begin
                    // Done phase lasts one cycle, the yield cycle
                    phase[sel] <= fx2_packet_pkg::PHASE_WAITING;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: logic/fx2_endpoint_scheduler.sv
// ======================================================================
// FX2 endpoint scheduler
// Round-robin over EP2, EP4 and EP8, advanced by engine yields
// ======================================================================
`timescale 1ns/1ps
`default_nettype none

module fx2_endpoint_scheduler (
    input wire usb_ifclk,
    input wire reset,
    input wire reader_yield,
    input wire writer_yield,
    output fx2_bus_pkg::ep_addr_t usb_addr,
    output logic ep2_grant,
    output logic ep4_grant,
    output logic ep8_grant
);

    // Endpoint currently being served
    fx2_bus_pkg::ep_addr_t cur_ep;
    fx2_bus_pkg::ep_addr_t next_ep;

    // EP6 is not served, so EP4 hands straight over to EP8
    always_comb begin
        case (cur_ep)
            fx2_bus_pkg::EP2: next_ep = fx2_bus_pkg::EP4;
            fx2_bus_pkg::EP4: next_ep = fx2_bus_pkg::EP8;
            fx2_bus_pkg::EP6,
            fx2_bus_pkg::EP8: next_ep = fx2_bus_pkg::EP_FIRST;
            default: next_ep = fx2_bus_pkg::EP_FIRST;
        endcase
    end

    // A yield pulse moves the grant on the following clock
    always_ff @(posedge usb_ifclk) begin
        if (reset) begin
            cur_ep <= fx2_bus_pkg::EP_FIRST;
        end else if (reader_yield || writer_yield) begin
            cur_ep <= next_ep;
        end
    end

    // The FX2 FIFO address simply follows the served endpoint
    assign usb_addr = cur_ep;

    assign ep2_grant = (cur_ep == fx2_bus_pkg::EP2);
    assign ep4_grant = (cur_ep == fx2_bus_pkg::EP4);
    assign ep8_grant = (cur_ep == fx2_bus_pkg::EP8);

endmodule

`default_nettype wire

// File: common/fx2_packet_pkg.sv
// ======================================================================
// FX2 packet framing types
// Phase of a packet and the two meanings of the byte after the header
// ======================================================================
`default_nettype none

package fx2_packet_pkg;

    // Phase of a packet on one endpoint, kept per endpoint
    typedef enum logic [2:0] {
        PHASE_WAITING = 3'd0,
        PHASE_HEADER_SELECT = 3'd1,
        PHASE_LENGTH_UPPER = 3'd2,
        PHASE_LENGTH_LOWER = 3'd3,
        PHASE_DATA = 3'd4,
        PHASE_DONE = 3'd5
    } packet_phase_t;

    // On EP2 the select byte carries a port number in its low bits
    typedef struct packed {
        logic [5:0] reserved;
        logic [1:0] port;
    } port_select_t;

    // The select byte is a port select on EP2 and a command ID on EP4
    typedef union packed {
        port_select_t port_sel;
        logic [7:0] command_id;
    } header_word_u;

endpackage

`default_nettype wire

// File: common/fx2_bus_pkg.sv
// ======================================================================
// FX2 bus definitions
// Endpoint address encoding and strobe levels of the slave-FIFO bus
// ======================================================================
`default_nettype none

package fx2_bus_pkg;

    // Same encoding as the FX2 FIFOADR pins
    // EP6 stays in the encoding even though nothing here serves it
    typedef enum logic [1:0] {
        EP2 = 2'd0,
        EP4 = 2'd1,
        EP6 = 2'd2,
        EP8 = 2'd3
    } ep_addr_t;

    // First endpoint visited after reset and after EP8
    localparam ep_addr_t EP_FIRST = EP2;

    // SLRD and SLWR are both active low
    localparam logic STROBE_ACTIVE = 1'b0;
    localparam logic STROBE_IDLE = 1'b1;

endpackage

`default_nettype wire

// File: common/fx2_cfg.svh
// ======================================================================
// FX2 slave-FIFO configuration
// Sizes and constants shared by the reader, writer and top level
// ======================================================================
`ifndef FX2_CFG_SVH
`define FX2_CFG_SVH

// Start-of-packet marker on every endpoint
`define FX2_HEADER_BYTE 8'hFF

// Width of the FX2 slave-FIFO data bus
`define FX2_DATA_W 8

// Packet length field, sent big-endian as two bus bytes
`define FX2_LEN_W 16

// Number of tracking-FIFO write ports fed from EP2
`define FX2_NUM_PORTS 4

// Idle cycles in a row before an EP8 data phase is abandoned
`define FX2_EP8_WAIT_CYCLES 4

`endif
